/* verilog/cpu_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, opcodes and encodings of the four-stage integer pipeline
// referenced by scoped names from every RTL module
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI                                 // passes operand b
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JUMP
    } branch_t;

    // major opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_J        = 6'h02;
    localparam logic [5:0] OP_BEQ      = 6'h04;
    localparam logic [5:0] OP_BNE      = 6'h05;
    localparam logic [5:0] OP_ADDIU    = 6'h09;
    localparam logic [5:0] OP_ORI      = 6'h0d;
    localparam logic [5:0] OP_LUI      = 6'h0f;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;

    // function codes, inst[5:0]
    localparam logic [5:0] FUNCT_MUL   = 6'h02;  // under SPECIAL2
    localparam logic [5:0] FUNCT_ADDU  = 6'h21;
    localparam logic [5:0] FUNCT_SUBU  = 6'h23;
    localparam logic [5:0] FUNCT_AND   = 6'h24;
    localparam logic [5:0] FUNCT_OR    = 6'h25;
    localparam logic [5:0] FUNCT_XOR   = 6'h26;
    localparam logic [5:0] FUNCT_SLT   = 6'h2a;

    localparam word_t DEFAULT_RESET_PC = 32'hbfc0_0000;

endpackage

`default_nettype wire

/* verilog/reg_file.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 register file with two read ports and one write port
// register 0 reads zero and a write shows through to same-cycle reads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire logic                aclk,
    input  wire logic                reset,
    input  cpu_pkg::reg_addr_t       rs_addr,
    input  cpu_pkg::reg_addr_t       rt_addr,
    output cpu_pkg::word_t           rs_data,
    output cpu_pkg::word_t           rt_data,
    input  wire logic                wb_we,
    input  cpu_pkg::reg_addr_t       wb_dst,
    input  cpu_pkg::word_t           wb_data
);
    cpu_pkg::word_t regs [2**cpu_pkg::REG_ADDR_W];

    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < 2**cpu_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_dst != '0) begin
            regs[wb_dst] <= wb_data;
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 :
                     (wb_we && wb_dst == rs_addr) ? wb_data : regs[rs_addr];  // same-cycle write
    assign rt_data = (rt_addr == '0) ? '0 :
                     (wb_we && wb_dst == rt_addr) ? wb_data : regs[rt_addr];

endmodule

`default_nettype wire

/* verilog/mul_unit.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iterative shift-add multiplier, one partial product per cycle
// start pulses once, done pulses with the low product word 32 cycles later
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module mul_unit (
    input  wire logic           aclk,
    input  wire logic           reset,
    input  wire logic           mul_start,
    input  cpu_pkg::word_t      mul_a,
    input  cpu_pkg::word_t      mul_b,
    output logic                mul_busy,
    output logic                mul_done,
    output cpu_pkg::word_t      mul_product
);
    localparam int MUL_CYCLES = cpu_pkg::XLEN;
    localparam int CNT_W      = $clog2(MUL_CYCLES);

    logic [CNT_W-1:0]   cnt;
    cpu_pkg::word_t     a_sh, b_sh, acc;
    cpu_pkg::word_t     step_add;

    assign step_add = b_sh[0] ? a_sh : '0;

    always_ff @(posedge aclk) begin
        if (reset) begin
            mul_busy <= 1'b0;
            cnt      <= '0;
        end else if (mul_start) begin
            mul_busy <= 1'b1;
            cnt      <= CNT_W'(1);              // bit 0 handled at start
        end else if (mul_busy) begin
            cnt <= cnt + 1'b1;
            if (mul_done) begin
                mul_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (mul_start) begin
            acc  <= mul_b[0] ? mul_a : '0;
            a_sh <= mul_a << 1;
            b_sh <= mul_b >> 1;
        end else if (mul_busy) begin
            acc  <= acc + step_add;
            a_sh <= a_sh << 1;
            b_sh <= b_sh >> 1;
        end
    end

    // last bit folded in combinationally so the op spans exactly MUL_CYCLES
    assign mul_done    = mul_busy && (cnt == CNT_W'(MUL_CYCLES - 1));
    assign mul_product = acc + step_add;

endmodule

`default_nettype wire

/* verilog/hazard_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipeline write enables and flushes from multiplier stall and redirect
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module hazard_ctrl (
    input  wire logic   mul_busy,
    input  wire logic   redirect,
    output logic        fetch_wr,
    output logic        dec_wr,
    output logic        exe_wr,
    output logic        dec_flush,
    output logic        exe_flush
);
    // a running mul freezes every stage up to execute
    assign fetch_wr = !mul_busy;
    assign dec_wr   = !mul_busy;
    assign exe_wr   = !mul_busy;

    // taken branch kills fetch and decode slots, registers load bubbles
    assign dec_flush = redirect;
    assign exe_flush = redirect;

endmodule

`default_nettype wire

/* verilog/fetch_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter, drives the instruction port and the pc into decode
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
    parameter cpu_pkg::word_t RESET_PC = cpu_pkg::DEFAULT_RESET_PC
) (
    input  wire logic           aclk,
    input  wire logic           reset,
    input  wire logic           fetch_wr,
    input  wire logic           redirect,
    input  cpu_pkg::word_t      redirect_pc,
    output cpu_pkg::word_t      fetch_pc,
    output cpu_pkg::word_t      inst_addr
);
    cpu_pkg::word_t pc;

    always_ff @(posedge aclk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;          // taken branch or jump from execute
        end else if (fetch_wr) begin
            pc <= pc + 32'd4;
        end
    end

    assign inst_addr = pc;
    assign fetch_pc  = pc;              // travels with inst_rdata into IF/ID

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IF/ID register, instruction decode and operand bypass from execute
// writeback values reach decode through the register file write-through
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  wire logic                aclk,
    input  wire logic                reset,
    input  wire logic                dec_wr,
    input  wire logic                dec_flush,
    input  cpu_pkg::word_t           fetch_pc,
    input  cpu_pkg::word_t           inst_rdata,
    output cpu_pkg::reg_addr_t       rs_addr,
    output cpu_pkg::reg_addr_t       rt_addr,
    input  cpu_pkg::word_t           rs_data,
    input  cpu_pkg::word_t           rt_data,
    input  wire logic                ex_fwd_valid,
    input  cpu_pkg::reg_addr_t       ex_dst,
    input  cpu_pkg::word_t           ex_result,
    output logic                     id_valid,
    output cpu_pkg::word_t           id_pc,
    output cpu_pkg::alu_op_t         id_alu_op,
    output cpu_pkg::branch_t         id_branch,
    output logic                     id_is_mul,
    output logic                     id_use_imm,
    output cpu_pkg::word_t           id_imm,
    output cpu_pkg::word_t           id_target,
    output cpu_pkg::reg_addr_t       id_dst,
    output logic                     id_we,
    output cpu_pkg::word_t           id_opa,
    output cpu_pkg::word_t           id_opb
);
    logic               if_valid;
    cpu_pkg::word_t     if_pc;
    cpu_pkg::word_t     if_inst;
    cpu_pkg::word_t     pc_plus4;
    cpu_pkg::word_t     imm_sext;
    logic               writes;                     // before the r0 filter

    always_ff @(posedge aclk) begin
        if (reset || dec_flush) begin
            if_valid <= 1'b0;                       // bubble
        end else if (dec_wr) begin
            if_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (dec_wr) begin
            if_pc   <= fetch_pc;
            if_inst <= inst_rdata;
        end
    end

    assign rs_addr  = if_inst[25:21];
    assign rt_addr  = if_inst[20:16];
    assign pc_plus4 = if_pc + 32'd4;
    assign imm_sext = {{16{if_inst[15]}}, if_inst[15:0]};

    always_comb begin
        id_alu_op  = cpu_pkg::ALU_ADD;
        id_branch  = cpu_pkg::BR_NONE;
        id_is_mul  = 1'b0;
        id_use_imm = 1'b0;
        id_imm     = imm_sext;
        id_target  = pc_plus4 + {imm_sext[29:0], 2'b00};
        id_dst     = if_inst[15:11];                // rd
        writes     = 1'b0;
        case (if_inst[31:26])
            cpu_pkg::OP_SPECIAL: begin
                writes = 1'b1;
                case (if_inst[5:0])
                    cpu_pkg::FUNCT_ADDU: id_alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FUNCT_SUBU: id_alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FUNCT_AND:  id_alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FUNCT_OR:   id_alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FUNCT_XOR:  id_alu_op = cpu_pkg::ALU_XOR;
                    cpu_pkg::FUNCT_SLT:  id_alu_op = cpu_pkg::ALU_SLT;
                    default:             writes = 1'b0;     // no-op
                endcase
            end
            cpu_pkg::OP_SPECIAL2: begin
                id_is_mul = (if_inst[5:0] == cpu_pkg::FUNCT_MUL);
                writes    = id_is_mul;
            end
            cpu_pkg::OP_ADDIU: begin
                id_use_imm = 1'b1;
                id_dst     = rt_addr;
                writes     = 1'b1;
            end
            cpu_pkg::OP_ORI: begin
                id_alu_op  = cpu_pkg::ALU_OR;
                id_use_imm = 1'b1;
                id_imm     = {16'h0, if_inst[15:0]};       // zero extended
                id_dst     = rt_addr;
                writes     = 1'b1;
            end
            cpu_pkg::OP_LUI: begin
                id_alu_op  = cpu_pkg::ALU_LUI;
                id_use_imm = 1'b1;
                id_imm     = {if_inst[15:0], 16'h0};
                id_dst     = rt_addr;
                writes     = 1'b1;
            end
            cpu_pkg::OP_BEQ: id_branch = cpu_pkg::BR_BEQ;
            cpu_pkg::OP_BNE: id_branch = cpu_pkg::BR_BNE;
            cpu_pkg::OP_J: begin
                id_branch = cpu_pkg::BR_JUMP;
                id_target = {pc_plus4[31:28], if_inst[25:0], 2'b00};
            end
            default: ;                                  // unknown, retires as no-op
        endcase
    end

    assign id_valid = if_valid;
    assign id_pc    = if_pc;
    assign id_we    = writes && (id_dst != '0);     // r0 writes are dropped

    // execute result wins over the register file
    assign id_opa = (ex_fwd_valid && ex_dst == rs_addr) ? ex_result : rs_data;
    assign id_opb = (ex_fwd_valid && ex_dst == rt_addr) ? ex_result : rt_data;

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ID/EXE register, ALU, branch resolution and the EXE/WB register
// EXE/WB feeds the register file write port and the golden trace outputs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  wire logic                aclk,
    input  wire logic                reset,
    input  wire logic                exe_wr,
    input  wire logic                exe_flush,
    input  wire logic                id_valid,
    input  cpu_pkg::word_t           id_pc,
    input  cpu_pkg::alu_op_t         id_alu_op,
    input  cpu_pkg::branch_t         id_branch,
    input  wire logic                id_is_mul,
    input  wire logic                id_use_imm,
    input  cpu_pkg::word_t           id_imm,
    input  cpu_pkg::word_t           id_target,
    input  cpu_pkg::reg_addr_t       id_dst,
    input  wire logic                id_we,
    input  cpu_pkg::word_t           id_opa,
    input  cpu_pkg::word_t           id_opb,
    output logic                     redirect,
    output cpu_pkg::word_t           redirect_pc,
    output logic                     mul_busy,
    output logic                     ex_fwd_valid,
    output cpu_pkg::reg_addr_t       ex_dst,
    output cpu_pkg::word_t           ex_result,
    output logic                     wb_we,
    output cpu_pkg::reg_addr_t       wb_dst,
    output cpu_pkg::word_t           wb_data,
    output logic                     debug_wb_valid,
    output cpu_pkg::word_t           debug_wb_pc,
    output cpu_pkg::word_t           debug_wb_rf_wdata,
    output logic [3:0]               debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t       debug_wb_rf_wnum
);
    logic                ex_valid, ex_is_mul, ex_use_imm, ex_we;
    cpu_pkg::word_t      ex_pc, ex_imm, ex_target, ex_opa, ex_opb;
    cpu_pkg::alu_op_t    ex_alu_op;
    cpu_pkg::branch_t    ex_branch;
    cpu_pkg::word_t      alu_b, alu_out;
    logic                mul_start, mul_done, unit_busy;
    cpu_pkg::word_t      mul_product;
    logic                wb_valid;
    cpu_pkg::word_t      wb_pc;

    always_ff @(posedge aclk) begin
        if (reset || exe_flush) begin
            ex_valid <= 1'b0;
        end else if (exe_wr) begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (exe_wr) begin
            ex_pc      <= id_pc;
            ex_alu_op  <= id_alu_op;
            ex_branch  <= id_branch;
            ex_is_mul  <= id_is_mul;
            ex_use_imm <= id_use_imm;
            ex_imm     <= id_imm;
            ex_target  <= id_target;
            ex_dst     <= id_dst;
            ex_we      <= id_we;
            ex_opa     <= id_opa;
            ex_opb     <= id_opb;
        end
    end

    assign alu_b = ex_use_imm ? ex_imm : ex_opb;

    always_comb begin
        case (ex_alu_op)
            cpu_pkg::ALU_SUB: alu_out = ex_opa - alu_b;
            cpu_pkg::ALU_AND: alu_out = ex_opa & alu_b;
            cpu_pkg::ALU_OR:  alu_out = ex_opa | alu_b;
            cpu_pkg::ALU_XOR: alu_out = ex_opa ^ alu_b;
            cpu_pkg::ALU_SLT: alu_out = {31'h0, $signed(ex_opa) < $signed(alu_b)};
            cpu_pkg::ALU_LUI: alu_out = alu_b;
            default:          alu_out = ex_opa + alu_b;
        endcase
    end

    // no delay slot, taken branches retire and kill the two younger slots
    always_comb begin
        case (ex_branch)
            cpu_pkg::BR_BEQ:  redirect = ex_valid && (ex_opa == ex_opb);
            cpu_pkg::BR_BNE:  redirect = ex_valid && (ex_opa != ex_opb);
            cpu_pkg::BR_JUMP: redirect = ex_valid;
            default:          redirect = 1'b0;
        endcase
    end
    assign redirect_pc = ex_target;

    assign mul_start    = ex_valid && ex_is_mul && !unit_busy;   // first mul cycle
    assign mul_busy     = ex_valid && ex_is_mul && !mul_done;    // freezes the pipe
    assign ex_result    = ex_is_mul ? mul_product : alu_out;
    assign ex_fwd_valid = ex_valid && ex_we && !mul_busy;

    mul_unit mul_unit_i (
        .aclk, .reset, .mul_start, .mul_a(ex_opa), .mul_b(ex_opb),
        .mul_busy(unit_busy), .mul_done, .mul_product
    );

    always_ff @(posedge aclk) begin
        if (reset) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            wb_valid <= ex_valid && !mul_busy;          // bubble while stalled
            wb_we    <= ex_valid && !mul_busy && ex_we;
        end
    end

    always_ff @(posedge aclk) begin
        wb_pc   <= ex_pc;
        wb_dst  <= ex_dst;
        wb_data <= ex_result;
    end

    assign debug_wb_valid    = wb_valid;
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wdata = wb_data;
    assign debug_wb_rf_wen   = {4{wb_we}};
    assign debug_wb_rf_wnum  = wb_dst;

endmodule

`default_nettype wire

/* verilog/mycpu_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU top level, wires fetch, decode, execute, register file and hazard unit
// instruction port is a combinational read, debug trace comes from writeback
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module mycpu_top #(
    parameter cpu_pkg::word_t RESET_PC = cpu_pkg::DEFAULT_RESET_PC
) (
    input  wire logic                aclk,
    input  wire logic                reset,
    output cpu_pkg::word_t           inst_addr,
    input  cpu_pkg::word_t           inst_rdata,
    output logic                     debug_wb_valid,
    output cpu_pkg::word_t           debug_wb_pc,
    output cpu_pkg::word_t           debug_wb_rf_wdata,
    output logic [3:0]               debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t       debug_wb_rf_wnum
);
    logic                fetch_wr, dec_wr, exe_wr;   // from hazard_ctrl
    logic                dec_flush, exe_flush;
    logic                redirect;                   // from execute
    cpu_pkg::word_t      redirect_pc;
    logic                mul_busy;
    cpu_pkg::word_t      fetch_pc;
    cpu_pkg::reg_addr_t  rs_addr, rt_addr;
    cpu_pkg::word_t      rs_data, rt_data;
    logic                ex_fwd_valid;               // execute bypass
    cpu_pkg::reg_addr_t  ex_dst;
    cpu_pkg::word_t      ex_result;
    logic                wb_we;                      // writeback port
    cpu_pkg::reg_addr_t  wb_dst;
    cpu_pkg::word_t      wb_data;

    // decode to execute
    logic                id_valid, id_is_mul, id_use_imm, id_we;
    cpu_pkg::word_t      id_pc, id_imm, id_target, id_opa, id_opb;
    cpu_pkg::alu_op_t    id_alu_op;
    cpu_pkg::branch_t    id_branch;
    cpu_pkg::reg_addr_t  id_dst;

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_i (
        .aclk, .reset, .fetch_wr, .redirect, .redirect_pc, .fetch_pc, .inst_addr
    );

    decode_stage decode_stage_i (
        .aclk, .reset, .dec_wr, .dec_flush, .fetch_pc, .inst_rdata,
        .rs_addr, .rt_addr, .rs_data, .rt_data, .ex_fwd_valid, .ex_dst, .ex_result,
        .id_valid, .id_pc, .id_alu_op, .id_branch, .id_is_mul, .id_use_imm,
        .id_imm, .id_target, .id_dst, .id_we, .id_opa, .id_opb
    );

    reg_file reg_file_i (
        .aclk, .reset, .rs_addr, .rt_addr, .rs_data, .rt_data, .wb_we, .wb_dst, .wb_data
    );

    execute_stage execute_stage_i (
        .aclk, .reset, .exe_wr, .exe_flush,
        .id_valid, .id_pc, .id_alu_op, .id_branch, .id_is_mul, .id_use_imm,
        .id_imm, .id_target, .id_dst, .id_we, .id_opa, .id_opb,
        .redirect, .redirect_pc, .mul_busy, .ex_fwd_valid, .ex_dst, .ex_result,
        .wb_we, .wb_dst, .wb_data,
        .debug_wb_valid, .debug_wb_pc, .debug_wb_rf_wdata, .debug_wb_rf_wen,
        .debug_wb_rf_wnum
    );

    hazard_ctrl hazard_ctrl_i (
        .mul_busy, .redirect, .fetch_wr, .dec_wr, .exe_wr, .dec_flush, .exe_flush
    );

endmodule

`default_nettype wire

/* verif/tb_mycpu.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for mycpu_top, serves the program from the stim file through a
// combinational instruction memory and checks the writeback retire trace
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_mycpu;

    localparam cpu_pkg::word_t RESET_PC        = 32'hbfc0_0000;
    localparam cpu_pkg::word_t NOP_WORD        = 32'h0000_0000;
    localparam int             STIM_DEPTH      = 256;
    localparam int             PROG_BASE       = 2;     // after the two count words
    localparam int             CYCLES_PER_WORD = 40;
    localparam int             TIMEOUT_MARGIN  = 200;
    localparam                 STIM_FILE       = "verif/cpu_stim.txt";

    logic                aclk;
    logic                reset;
    cpu_pkg::word_t      inst_addr;
    cpu_pkg::word_t      inst_rdata;
    logic                debug_wb_valid;
    cpu_pkg::word_t      debug_wb_pc;
    cpu_pkg::word_t      debug_wb_rf_wdata;
    logic [3:0]          debug_wb_rf_wen;
    cpu_pkg::reg_addr_t  debug_wb_rf_wnum;

    logic [31:0]         stim [STIM_DEPTH];
    int                  n_prog      = 0;
    int                  n_rec       = 0;
    int                  rec_base    = 0;       // first word of the retire records
    bit                  stim_loaded = 1'b0;
    int                  rec_idx     = 0;
    int                  error_count = 0;
    int                  reset_edges = 0;
    int unsigned         fetch_index;

    mycpu_top #(.RESET_PC(RESET_PC)) mycpu_top_i (
        .aclk, .reset, .inst_addr, .inst_rdata, .debug_wb_valid, .debug_wb_pc,
        .debug_wb_rf_wdata, .debug_wb_rf_wen, .debug_wb_rf_wnum
    );

    initial begin
        aclk = 1'b0;
    end

    always #5 aclk = ~aclk;                     // 10 ns period

    // combinational instruction memory, same-cycle answer to inst_addr
    always_comb begin
        fetch_index = (inst_addr - RESET_PC) >> 2;
        if (stim_loaded && inst_addr >= RESET_PC && fetch_index < n_prog) begin
            inst_rdata = stim[PROG_BASE + fetch_index];
        end else begin
            inst_rdata = NOP_WORD;              // outside the program
        end
    end

    task automatic compare_field(input string field, input int idx,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0d ns: record %0d %s expected %h actual %h",
                     $time, idx, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_retire(input int idx);
        int base;
        base = rec_base + 4 * idx;
        compare_field("pc", idx, stim[base], debug_wb_pc);
        compare_field("wen", idx, stim[base + 1], {28'h0, debug_wb_rf_wen});
        if (stim[base + 1] != 32'h0) begin      // register and value only on a write
            compare_field("wnum", idx, stim[base + 2], {27'h0, debug_wb_rf_wnum});
            compare_field("wdata", idx, stim[base + 3], debug_wb_rf_wdata);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d, retire records checked: %0d of %0d",
                 error_count, rec_idx, n_rec);
    endtask

    // trace checker, one record per retired instruction
    always @(posedge aclk) begin
        if (reset) begin
            if (reset_edges > 0 && debug_wb_valid !== 1'b0) begin
                $display("error at %0d ns: debug_wb_valid is %b during reset",
                         $time, debug_wb_valid);
                error_count++;
            end
            reset_edges++;
        end else if (debug_wb_valid === 1'b1 && rec_idx < n_rec) begin
            if (rec_idx == 0) begin
                compare_field("first pc against reset pc", 0, RESET_PC, debug_wb_pc);
            end
            check_retire(rec_idx);
            rec_idx++;
        end
    end

    initial begin
        reset = 1'b1;
        $readmemh(STIM_FILE, stim);
        n_prog   = stim[0];
        n_rec    = stim[1];
        rec_base = PROG_BASE + n_prog;
        if (n_prog < 1 || n_rec < 1 || rec_base + 4 * n_rec > STIM_DEPTH) begin
            $display("the stim file %s could not be read or its counts do not fit",
                     STIM_FILE);
            error_count++;
        end else begin
            stim_loaded = 1'b1;
            repeat (4) @(posedge aclk);
            @(negedge aclk);
            reset = 1'b0;                       // released on a falling edge
            wait (rec_idx >= n_rec);
            repeat (2) @(posedge aclk);
        end
        print_counts();
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog, scaled to the program length
    initial begin
        wait (stim_loaded);
        repeat (n_prog * CYCLES_PER_WORD + TIMEOUT_MARGIN) @(posedge aclk);
        $display("timeout, the retire trace did not complete within %0d cycles",
                 n_prog * CYCLES_PER_WORD + TIMEOUT_MARGIN);
        print_counts();
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/cpu_stim.txt */
// first two words give the program length and the retire record count
// then one instruction word per line, then retire records as pc wen reg value
00000017
00000013
24010005  // addiu r1, r0, 5
2402fffd  // addiu r2, r0, -3
00221821  // addu  r3, r1, r2
00612023  // subu  r4, r3, r1
3c051234  // lui   r5, 0x1234
34a55678  // ori   r5, r5, 0x5678
00a43026  // xor   r6, r5, r4
00c13824  // and   r7, r6, r1
00e54025  // or    r8, r7, r5
0081482a  // slt   r9, r4, r1
00210021  // addu  r0, r1, r1
00015021  // addu  r10, r0, r1
11410002  // beq   r10, r1, taken to 0x3c
241f0001  // addiu r31, r0, 1 must not retire
241f0002  // addiu r31, r0, 2 must not retire
14210005  // bne   r1, r1, falls through
70415802  // mul   r11, r2, r1
01626023  // subu  r12, r11, r2
71826802  // mul   r13, r12, r2
0bf00016  // j     0xbfc00058
241f0003  // addiu r31, r0, 3 must not retire
241f0004  // addiu r31, r0, 4 must not retire
01ac7021  // addu  r14, r13, r12
bfc00000 f 01 00000005
bfc00004 f 02 fffffffd
bfc00008 f 03 00000002
bfc0000c f 04 fffffffd
bfc00010 f 05 12340000
bfc00014 f 05 12345678
bfc00018 f 06 edcba985
bfc0001c f 07 00000005
bfc00020 f 08 1234567d
bfc00024 f 09 00000001
bfc00028 0 00 00000000  // r0 write dropped
bfc0002c f 0a 00000005
bfc00030 0 00 00000000  // beq
bfc0003c 0 00 00000000  // bne
bfc00040 f 0b fffffff1
bfc00044 f 0c fffffff4
bfc00048 f 0d 00000024
bfc0004c 0 00 00000000  // j
bfc00058 f 0e 00000018

/* files.f */
verilog/cpu_pkg.sv
verilog/reg_file.sv
verilog/mul_unit.sv
verilog/hazard_ctrl.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mycpu_top.sv
verif/tb_mycpu.sv

/* Bender.yml */
package:
  name: mycpu

sources:
  - verilog/cpu_pkg.sv
  - verilog/reg_file.sv
  - verilog/mul_unit.sv
  - verilog/hazard_ctrl.sv
  - verilog/fetch_stage.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/mycpu_top.sv
  - target: test
    files:
      - verif/tb_mycpu.sv
